// ==== ImgI2CSlave.f ====
+incdir+verilog
+incdir+testbench
verilog/I2CBusPkg.sv
verilog/ImgRegPkg.sv
verilog/I2CLineIf.sv
verilog/I2CByteIf.sv
verilog/I2CLineMonitor.sv
verilog/I2CByteEngine.sv
verilog/ImgRegParser.sv
verilog/ImgRegFile.sv
verilog/ImgI2CSlave.sv
testbench/ImgI2CSlaveTb.sv

// ==== testbench/I2CControllerTasks.svh ====
`ifndef I2CControllerTasks_svh
`define I2CControllerTasks_svh

// Controller side of the bus
// One bit is four phases of PhaseCycles clk cycles, pins change on falling clk edges

// Sets SDA in the low phase, raises SCL, samples SDA in the middle of the high phase
task automatic clockBit(input logic bitOut, output logic bitIn);
    repeat (PhaseCycles) @(negedge clk);
    sdaCtl = bitOut;
    repeat (PhaseCycles) @(negedge clk);
    scl = 1'b1;
    repeat (PhaseCycles) @(negedge clk);
    bitIn = sda;
    repeat (PhaseCycles) @(negedge clk);
    scl = 1'b0;
endtask

// START from an idle bus, or a repeated START while SCL is low
task automatic sendStart();
    repeat (PhaseCycles) @(negedge clk);
    sdaCtl = 1'b1;
    repeat (PhaseCycles) @(negedge clk);
    scl = 1'b1;
    repeat (PhaseCycles) @(negedge clk);
    sdaCtl = 1'b0;
    repeat (PhaseCycles) @(negedge clk);
    scl = 1'b0;
endtask

// STOP leaves both lines high
task automatic sendStop();
    repeat (PhaseCycles) @(negedge clk);
    sdaCtl = 1'b0;
    repeat (PhaseCycles) @(negedge clk);
    scl = 1'b1;
    repeat (PhaseCycles) @(negedge clk);
    sdaCtl = 1'b1;
    repeat (PhaseCycles) @(negedge clk);
endtask

// Byte out MSB first, then the target's answer in the ninth clock
task automatic writeByte(input logic [7:0] value, output logic ack);
    logic ignored;
    logic sdaLevel;
    for (int k = 7; k >= 0; k--) begin
        clockBit(value[k], ignored);
    end
    clockBit(1'b1, sdaLevel);
    ack = ~sdaLevel;
endtask

// Byte in MSB first; ACK when more bytes are wanted, NACK on the last one
task automatic readByte(input logic more, output logic [7:0] value);
    logic ignored;
    for (int k = 7; k >= 0; k--) begin
        clockBit(1'b1, value[k]);
    end
    clockBit(~more, ignored);
endtask

`endif

// ==== testbench/ImgI2CSlaveTb.sv ====
`timescale 1ns/1ps
`include "ImgI2C_macros.svh"

module ImgI2CSlaveTb;

    localparam int PhaseCycles = 8;
    localparam int BitCycles   = 4 * PhaseCycles;
    localparam int ClkPeriodNs = 8;
    localparam int IdleCycles  = 64;
    localparam int NumRows     = 12;
    // Longest row, a four-byte combined read, takes about 75 bit times
    localparam int RowBudgetBits = 80;
    localparam int TimeoutNs =
        (NumRows * RowBudgetBits * BitCycles + IdleCycles + 8) * ClkPeriodNs;
    localparam logic [6:0] Dev = `ImgI2CDefaultDevAddr;

    typedef struct packed {
        logic            isRead;
        logic [6:0]      devAddr;
        logic [15:0]     regAddr;
        logic [2:0]      count;
        logic            isRandom;
        logic [0:2][7:0] data;
        logic [0:2]      ack;
        logic            addrAck;
    } tableRow_t;

    // Read rows use only the address fields and the byte count
    localparam tableRow_t Rows [NumRows] = '{
        '{1'b0, Dev,   16'h0010, 3'd2, 1'b0, {8'ha5, 8'h5a, 8'h00}, 3'b110, 1'b1},
        '{1'b1, Dev,   16'h0010, 3'd2, 1'b0, 24'h0,                 3'b000, 1'b1},
        '{1'b0, 7'h3b, 16'h0010, 3'd2, 1'b0, {8'h11, 8'h22, 8'h00}, 3'b000, 1'b0},
        '{1'b1, Dev,   16'h0010, 3'd1, 1'b0, 24'h0,                 3'b000, 1'b1},
        '{1'b0, Dev,   16'h0022, 3'd1, 1'b0, {8'h77, 8'h00, 8'h00}, 3'b100, 1'b1},
        '{1'b0, Dev,   16'h0020, 3'd3, 1'b1, 24'h0,                 3'b110, 1'b1},
        '{1'b1, Dev,   16'h0020, 3'd3, 1'b0, 24'h0,                 3'b000, 1'b1},
        '{1'b0, Dev,   16'h1234, 3'd2, 1'b1, 24'h0,                 3'b110, 1'b1},
        '{1'b1, Dev,   16'h0034, 3'd2, 1'b0, 24'h0,                 3'b000, 1'b1},
        '{1'b0, Dev,   16'h00fe, 3'd2, 1'b1, 24'h0,                 3'b110, 1'b1},
        '{1'b0, Dev,   16'h0000, 3'd2, 1'b1, 24'h0,                 3'b110, 1'b1},
        '{1'b1, Dev,   16'h00fe, 3'd4, 1'b0, 24'h0,                 3'b000, 1'b1}
    };

    logic clk = 1'b0;
    logic arstN;
    logic scl;
    logic sdaCtl;
    logic sdaOe;
    logic quietWatch;
    wire  sda;

    // Expected storage, indexed by the low byte of the register address
    logic [7:0] model [256];

    // Open-drain bus with the controller's release level
    assign sda = sdaCtl & ~sdaOe;

    ImgI2CSlave dut (
        .clk   (clk),
        .arstN (arstN),
        .scl   (scl),
        .sdaIn (sda),
        .sdaOe (sdaOe)
    );

    always #(ClkPeriodNs / 2) clk = ~clk;

    `include "I2CControllerTasks.svh"

    task automatic reportError(input string msg);
        $display("** Error at %0t: %s", $time, msg);
        $display("TB FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic checkAck(input int rowNum, input string what, input logic got,
                            input logic exp);
        assert (got === exp) else
            reportError($sformatf("row %0d %s ack %b, expected %b", rowNum, what, got, exp));
    endtask

    task automatic runWrite(input int rowNum, input tableRow_t row);
        logic       ack;
        logic [7:0] idx;
        // A target that NACKs its address must leave SDA alone until STOP
        quietWatch = ~row.addrAck;
        sendStart();
        writeByte({row.devAddr, 1'b0}, ack);
        checkAck(rowNum, "device address", ack, row.addrAck);
        if (ack) begin
            writeByte(row.regAddr[15:8], ack);
            checkAck(rowNum, "address high", ack, 1'b1);
            writeByte(row.regAddr[7:0], ack);
            checkAck(rowNum, "address low", ack, 1'b1);
            for (int j = 0; j < row.count; j++) begin
                writeByte(row.data[j], ack);
                checkAck(rowNum, $sformatf("data byte %0d", j), ack, row.ack[j]);
                if (!ack) begin
                    break;
                end
                idx = row.regAddr[7:0] + 8'(j);
                model[idx] = row.data[j];
            end
        end
        sendStop();
        quietWatch = 1'b0;
    endtask

    // Register address write, repeated START, then sequential read
    task automatic runRead(input int rowNum, input tableRow_t row);
        logic       ack;
        logic [7:0] got;
        logic [7:0] idx;
        sendStart();
        writeByte({row.devAddr, 1'b0}, ack);
        checkAck(rowNum, "device address", ack, row.addrAck);
        writeByte(row.regAddr[15:8], ack);
        checkAck(rowNum, "address high", ack, 1'b1);
        writeByte(row.regAddr[7:0], ack);
        checkAck(rowNum, "address low", ack, 1'b1);
        sendStart();
        writeByte({row.devAddr, 1'b1}, ack);
        checkAck(rowNum, "read address", ack, 1'b1);
        for (int j = 0; j < row.count; j++) begin
            readByte(j != row.count - 1, got);
            idx = row.regAddr[7:0] + 8'(j);
            assert (got === model[idx]) else
                reportError($sformatf("row %0d read byte %0d got %02h, expected %02h",
                                      rowNum, j, got, model[idx]));
        end
        // After the final NACK the target stays off SDA through STOP
        quietWatch = 1'b1;
        sendStop();
        quietWatch = 1'b0;
    endtask

    always @(negedge clk) begin
        if (quietWatch) begin
            assert (sdaOe === 1'b0) else
                reportError("sdaOe high while the target should be silent");
        end
    end

    initial begin
        #(TimeoutNs);
        $display("Watchdog expired after %0d ns, the run hung", TimeoutNs);
        $display("TB FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        tableRow_t row;
        void'($urandom(32'ha9d1a7c9));
        arstN      = 1'b1;
        scl        = 1'b1;
        sdaCtl     = 1'b1;
        quietWatch = 1'b0;
        @(negedge clk);
        arstN = 1'b0;
        @(posedge clk);
        quietWatch = 1'b1;
        repeat (3) @(negedge clk);
        arstN = 1'b1;
        // Idle bus after reset
        repeat (IdleCycles) @(negedge clk);
        quietWatch = 1'b0;

        for (int i = 0; i < NumRows; i++) begin
            row = Rows[i];
            if (row.isRandom) begin
                for (int j = 0; j < 3; j++) begin
                    row.data[j] = 8'($urandom);
                end
            end
            if (row.isRead) begin
                runRead(i, row);
            end else begin
                runWrite(i, row);
            end
            repeat (BitCycles) @(negedge clk);
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== verilog/I2CBusPkg.sv ====
package I2CBusPkg;

    // One byte as it travels on SDA, MSB first
    typedef logic [7:0] i2cByte_t;

    // Device address without the R/W bit
    typedef logic [6:0] i2cDevAddr_t;

    // Bit-level phases of the byte engine
    // idle    waiting for START
    // rxBits  shifting in eight bits from the controller
    // ackOut  waiting for and then holding our ACK slot
    // txBits  shifting out eight bits to the controller
    // ackIn   sampling the controller's ACK
    typedef enum logic [2:0] {
        idle,
        rxBits,
        ackOut,
        txBits,
        ackIn
    } byteEngineState_t;

endpackage

// ==== verilog/I2CByteEngine.sv ====
`timescale 1ns/1ps

module I2CByteEngine import I2CBusPkg::*; (
    input  logic     clk,
    input  logic     arstN,
    I2CLineIf.engine line,
    I2CByteIf.engine bytes,
    output logic     sdaOe
);

    byteEngineState_t state;

    // Bits handled so far in the current byte
    logic [2:0] bitCnt;

    // Receive and transmit share one shift register
    i2cByte_t shiftReg;

    // Set once the ninth clock of a byte has begun
    logic slotOpen;

    assign bytes.rxByte = shiftReg;
    assign bytes.start  = line.start;
    assign bytes.stop   = line.stop;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state           <= idle;
            bitCnt          <= '0;
            shiftReg        <= '0;
            slotOpen        <= 1'b0;
            sdaOe           <= 1'b0;
            bytes.rxValid   <= 1'b0;
            bytes.txDone    <= 1'b0;
            bytes.masterAck <= 1'b0;
        end else begin
            bytes.rxValid <= 1'b0;
            bytes.txDone  <= 1'b0;

            if (line.start || line.stop) begin
                // Any bus condition drops the drive and restarts the byte
                state    <= line.start ? rxBits : idle;
                bitCnt   <= '0;
                slotOpen <= 1'b0;
                sdaOe    <= 1'b0;
            end else begin
                case (state)
                    rxBits: begin
                        if (line.sclRise) begin
                            shiftReg <= {shiftReg[6:0], line.sdaBit};
                            bitCnt   <= bitCnt + 3'd1;
                            if (bitCnt == 3'd7) begin
                                bytes.rxValid <= 1'b1;
                                state         <= ackOut;
                            end
                        end
                    end

                    ackOut: begin
                        if (line.sclFall && !slotOpen) begin
                            // Parser has decided by now
                            sdaOe    <= bytes.ackEn;
                            slotOpen <= 1'b1;
                        end else if (line.sclFall) begin
                            slotOpen <= 1'b0;
                            bitCnt   <= '0;
                            if (!sdaOe) begin
                                // NACK given, nothing more until START or STOP
                                state <= idle;
                            end else if (bytes.txMode) begin
                                shiftReg <= bytes.txByte;
                                sdaOe    <= ~bytes.txByte[7];
                                state    <= txBits;
                            end else begin
                                sdaOe <= 1'b0;
                                state <= rxBits;
                            end
                        end
                    end

                    txBits: begin
                        if (line.sclFall) begin
                            if (bitCnt == 3'd7) begin
                                // Release SDA for the controller's ACK
                                sdaOe <= 1'b0;
                                state <= ackIn;
                            end else begin
                                shiftReg <= {shiftReg[6:0], 1'b0};
                                sdaOe    <= ~shiftReg[6];
                                bitCnt   <= bitCnt + 3'd1;
                            end
                        end
                    end

                    ackIn: begin
                        if (line.sclRise && !slotOpen) begin
                            bytes.masterAck <= ~line.sdaBit;
                            bytes.txDone    <= 1'b1;
                            if (line.sdaBit) begin
                                state <= idle;
                            end else begin
                                slotOpen <= 1'b1;
                            end
                        end else if (line.sclFall && slotOpen) begin
                            // Pointer has advanced, so txByte is the next byte
                            slotOpen <= 1'b0;
                            bitCnt   <= '0;
                            shiftReg <= bytes.txByte;
                            sdaOe    <= ~bytes.txByte[7];
                            state    <= txBits;
                        end
                    end

                    default: begin
                        state <= idle;
                    end
                endcase
            end
        end
    end

endmodule

// ==== verilog/I2CByteIf.sv ====
`timescale 1ns/1ps

interface I2CByteIf import I2CBusPkg::*;;

    // Received byte, valid while rxValid is high
    logic     rxValid;
    i2cByte_t rxByte;

    // End of a sent byte and the controller's answer
    // masterAck high means ACK
    logic     txDone;
    logic     masterAck;

    // Bus conditions passed through from the line monitor
    logic     start;
    logic     stop;

    // ACK decision for the byte just received
    logic     ackEn;

    // High while the target sends the following bytes
    logic     txMode;

    // Byte to send next, taken at the end of the ACK slot
    i2cByte_t txByte;

    modport engine (
        output rxValid,
        output rxByte,
        output txDone,
        output masterAck,
        output start,
        output stop,
        input  ackEn,
        input  txMode,
        input  txByte
    );

    modport parser (
        input  rxValid,
        input  rxByte,
        input  txDone,
        input  masterAck,
        input  start,
        input  stop,
        output ackEn,
        output txMode,
        output txByte
    );

endinterface

// ==== verilog/I2CLineIf.sv ====
`timescale 1ns/1ps

interface I2CLineIf;

    // SCL edges, one clk cycle each
    logic sclRise;
    logic sclFall;

    // Synchronized SDA level, aligned with the edge pulses
    logic sdaBit;

    // Bus conditions while SCL is high
    // start also covers a repeated START
    logic start;
    logic stop;

    modport monitor (
        output sclRise,
        output sclFall,
        output sdaBit,
        output start,
        output stop
    );

    modport engine (
        input sclRise,
        input sclFall,
        input sdaBit,
        input start,
        input stop
    );

endinterface

// ==== verilog/I2CLineMonitor.sv ====
`timescale 1ns/1ps
`include "ImgI2C_macros.svh"

module I2CLineMonitor (
    input  logic     clk,
    input  logic     arstN,
    input  logic     scl,
    input  logic     sdaIn,
    I2CLineIf.monitor line
);

    // Synchronizer chains, newest sample in bit 0
    logic [`ImgI2CSyncStages-1:0] sclSync;
    logic [`ImgI2CSyncStages-1:0] sdaSync;

    // Synchronized levels and their one-cycle delayed copies
    logic sclNow;
    logic sdaNow;
    logic sclDly;
    logic sdaDly;

    assign sclNow = sclSync[`ImgI2CSyncStages-1];
    assign sdaNow = sdaSync[`ImgI2CSyncStages-1];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            // Idle bus has both lines high
            sclSync      <= '1;
            sdaSync      <= '1;
            sclDly       <= 1'b1;
            sdaDly       <= 1'b1;
            line.sclRise <= 1'b0;
            line.sclFall <= 1'b0;
            line.start   <= 1'b0;
            line.stop    <= 1'b0;
            line.sdaBit  <= 1'b1;
        end else begin
            sclSync <= {sclSync[`ImgI2CSyncStages-2:0], scl};
            sdaSync <= {sdaSync[`ImgI2CSyncStages-2:0], sdaIn};
            sclDly  <= sclNow;
            sdaDly  <= sdaNow;

            // Events are registered so all of them share the same latency
            line.sclRise <= sclNow & ~sclDly;
            line.sclFall <= ~sclNow & sclDly;

            // SDA falling with SCL high is START, rising is STOP
            line.start   <= sclNow & sdaDly & ~sdaNow;
            line.stop    <= sclNow & ~sdaDly & sdaNow;

            line.sdaBit  <= sdaNow;
        end
    end

endmodule

// ==== verilog/ImgI2CSlave.sv ====
`timescale 1ns/1ps
`include "ImgI2C_macros.svh"

module ImgI2CSlave import I2CBusPkg::*, ImgRegPkg::*; #(
    parameter i2cDevAddr_t DevAddr = `ImgI2CDefaultDevAddr
) (
    input  logic clk,
    input  logic arstN,
    input  logic scl,
    input  logic sdaIn,
    output logic sdaOe
);

    // Bus events and byte events between the stages
    I2CLineIf lineBus();
    I2CByteIf byteBus();

    // Storage ports
    logic      wrEn;
    regIndex_t wrIndex;
    regData_t  wrData;
    regIndex_t rdIndex;
    regData_t  rdData;

    I2CLineMonitor lineMonitor (
        .clk   (clk),
        .arstN (arstN),
        .scl   (scl),
        .sdaIn (sdaIn),
        .line  (lineBus.monitor)
    );

    I2CByteEngine byteEngine (
        .clk   (clk),
        .arstN (arstN),
        .line  (lineBus.engine),
        .bytes (byteBus.engine),
        .sdaOe (sdaOe)
    );

    ImgRegParser regParser (
        .clk     (clk),
        .arstN   (arstN),
        .bytes   (byteBus.parser),
        .devAddr (DevAddr),
        .wrEn    (wrEn),
        .wrIndex (wrIndex),
        .wrData  (wrData),
        .rdIndex (rdIndex),
        .rdData  (rdData)
    );

    ImgRegFile regFile (
        .clk     (clk),
        .wrEn    (wrEn),
        .wrIndex (wrIndex),
        .wrData  (wrData),
        .rdIndex (rdIndex),
        .rdData  (rdData)
    );

endmodule

// ==== verilog/ImgI2C_macros.svh ====
`ifndef ImgI2C_macros_svh
`define ImgI2C_macros_svh

// Flops on SCL and SDA ahead of edge detection
`define ImgI2CSyncStages 2

// Storage index width, 256 bytes
// Upper register address bits alias onto this range
`define ImgRegIndexBits 8

// 7-bit target address used when the board does not strap another one
`define ImgI2CDefaultDevAddr 7'h3c

`endif

// ==== verilog/ImgRegFile.sv ====
`timescale 1ns/1ps
`include "ImgI2C_macros.svh"

module ImgRegFile import ImgRegPkg::*; (
    input  logic      clk,
    input  logic      wrEn,
    input  regIndex_t wrIndex,
    input  regData_t  wrData,
    input  regIndex_t rdIndex,
    output regData_t  rdData
);

    // Configuration bytes, contents undefined until written
    regData_t mem [0:(1 << `ImgRegIndexBits)-1];

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrIndex] <= wrData;
        end
    end

    // Read is combinational so a byte can be loaded the moment it is needed
    assign rdData = mem[rdIndex];

endmodule

// ==== verilog/ImgRegParser.sv ====
`timescale 1ns/1ps
`include "ImgI2C_macros.svh"

module ImgRegParser import I2CBusPkg::*, ImgRegPkg::*; (
    input  logic        clk,
    input  logic        arstN,
    I2CByteIf.parser    bytes,
    input  i2cDevAddr_t devAddr,
    output logic        wrEn,
    output regIndex_t   wrIndex,
    output regData_t    wrData,
    output regIndex_t   rdIndex,
    input  regData_t    rdData
);

    parserState_t state;

    // Register pointer, kept across transactions for combined reads
    regAddr_t pointer;

    // Data bytes stored in the current write
    logic [1:0] writeCount;

    assign rdIndex      = pointer[`ImgRegIndexBits-1:0];
    assign bytes.txByte = rdData;

    // Write payload follows the pointer as it stood for this byte
    always_ff @(posedge clk) begin
        if (bytes.rxValid) begin
            wrIndex <= rdIndex;
            wrData  <= bytes.rxByte;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state        <= ImgRegPkg::devAddr;
            pointer      <= '0;
            writeCount   <= '0;
            wrEn         <= 1'b0;
            bytes.ackEn  <= 1'b0;
            bytes.txMode <= 1'b0;
        end else begin
            wrEn <= 1'b0;

            if (bytes.start || bytes.stop) begin
                state        <= ImgRegPkg::devAddr;
                bytes.ackEn  <= 1'b0;
                bytes.txMode <= 1'b0;
            end else begin
                case (state)
                    ImgRegPkg::devAddr: begin
                        if (bytes.rxValid && bytes.rxByte[7:1] == devAddr) begin
                            bytes.ackEn <= 1'b1;
                            if (bytes.rxByte[0]) begin
                                bytes.txMode <= 1'b1;
                                state        <= readData;
                            end else begin
                                writeCount <= '0;
                                state      <= addrHi;
                            end
                        end else if (bytes.rxValid) begin
                            // Another target on the bus
                            bytes.ackEn <= 1'b0;
                            state       <= ignore;
                        end
                    end

                    addrHi: begin
                        if (bytes.rxValid) begin
                            pointer[15:8] <= bytes.rxByte;
                            bytes.ackEn   <= 1'b1;
                            state         <= addrLo;
                        end
                    end

                    addrLo: begin
                        if (bytes.rxValid) begin
                            pointer[7:0] <= bytes.rxByte;
                            bytes.ackEn  <= 1'b1;
                            state        <= writeData;
                        end
                    end

                    writeData: begin
                        if (bytes.rxValid && writeCount != 2'd2) begin
                            wrEn        <= 1'b1;
                            pointer     <= pointer + 16'd1;
                            writeCount  <= writeCount + 2'd1;
                            bytes.ackEn <= 1'b1;
                        end else if (bytes.rxValid) begin
                            // Third data byte is refused
                            bytes.ackEn <= 1'b0;
                            state       <= ignore;
                        end
                    end

                    readData: begin
                        if (bytes.txDone) begin
                            pointer <= pointer + 16'd1;
                            if (!bytes.masterAck) begin
                                bytes.txMode <= 1'b0;
                                state        <= ignore;
                            end
                        end
                    end

                    ignore: begin
                    end

                    default: begin
                        state <= ignore;
                    end
                endcase
            end
        end
    end

endmodule

// ==== verilog/ImgRegPkg.sv ====
`include "ImgI2C_macros.svh"

package ImgRegPkg;

    // Register address as sent by the controller, high byte first
    typedef logic [15:0] regAddr_t;

    // One configuration register
    typedef logic [7:0] regData_t;

    // Low bits of the register address that select a storage byte
    typedef logic [`ImgRegIndexBits-1:0] regIndex_t;

    // Transaction phases of the register parser
    // devAddr    first byte after START, address and R/W bit
    // addrHi     register address high byte
    // addrLo     register address low byte
    // writeData  data bytes to be stored, at most two
    // readData   bytes supplied to the controller
    // ignore     wait for the next START or STOP
    typedef enum logic [2:0] {
        devAddr,
        addrHi,
        addrLo,
        writeData,
        readData,
        ignore
    } parserState_t;

endpackage
